/* all.f */
verilog/exec_pkg.sv
verilog/logic_unit.sv
verilog/shift_unit.sv
verilog/adder_unit.sv
verilog/exec_stage.sv
verilog/exec_top.sv
tb/tb_clock_gen.sv
tb/tb_exec_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_exec_top -f all.f > sim.log 2>&1 \
	&& ./obj_dir/Vtb_exec_top >> sim.log 2>&1 \
	|| echo "build or simulation returned an error" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0

/* tb/tb_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top
	import exec_pkg::*;
();

	localparam int WAIT_LIMIT = 16;	// Cycles allowed for any wait

	logic   clock;
	logic   rst_n;
	logic   in_valid;
	unit_t  unit;
	cmd_t   cmd;
	word_t  data0;
	word_t  data1;
	logic   out_valid;
	word_t  result;
	flags_t flags;

	// Stimulus and expected values, one entry per index
	unit_t  tbl_unit[$];
	cmd_t   tbl_cmd[$];
	word_t  tbl_data0[$];
	word_t  tbl_data1[$];
	word_t  tbl_result[$];
	flags_t tbl_flags[$];

	tb_clock_gen i_clock_gen
	(
		.clock (clock),
		.rst_n (rst_n)
	);

	exec_top i_exec_top
	(
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.unit      (unit),
		.cmd       (cmd),
		.data0     (data0),
		.data1     (data1),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %h got %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %h got %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flags(string name, flags_t exp, flags_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %h got %h", name, exp, act);
			stop_run();
		end
	endtask

	// sf, pf and zf follow the result, cf and of come from the unit
	function automatic flags_t flags_for(word_t res, logic cf, logic of);
		flags_t f;
		f.sf = res[31];
		f.of = of;
		f.cf = cf;
		f.pf = res[0];
		f.zf = (res == 32'h0);
		return f;
	endfunction

	task automatic table_push(unit_t u, cmd_t c, word_t a, word_t b, word_t res,
		logic cf, logic of);
		tbl_unit.push_back(u);
		tbl_cmd.push_back(c);
		tbl_data0.push_back(a);
		tbl_data1.push_back(b);
		tbl_result.push_back(res);
		tbl_flags.push_back(flags_for(res, cf, of));
	endtask

	task automatic log_entry(cmd_t c, word_t a, word_t b, word_t res);
		table_push(UNIT_LOGIC, c, a, b, res, 1'b0, 1'b0);
	endtask

	task automatic shift_entry(cmd_t c, word_t a, word_t b, word_t res, logic cf);
		table_push(UNIT_SHIFT, c, a, b, res, cf, 1'b0);
	endtask

	task automatic adder_entry(cmd_t c, word_t a, word_t b, word_t res, logic cf, logic of);
		table_push(UNIT_ADD, c, a, b, res, cf, of);
	endtask

	task automatic build_table();
		log_entry(LOG_BUF0, 32'h80000001, 32'h12345678, 32'h80000001);
		log_entry(LOG_BUF1, 32'h80000001, 32'h12345678, 32'h12345678);
		log_entry(LOG_INV0, 32'hFFFFFFFF, 32'h12345678, 32'h00000000);
		log_entry(LOG_INV1, 32'h00000000, 32'h0F0F0F0F, 32'hF0F0F0F0);
		log_entry(LOG_AND, 32'hF0F0FF00, 32'hFF00F0F0, 32'hF000F000);
		log_entry(LOG_OR, 32'hF0F0FF00, 32'hFF00F0F0, 32'hFFF0FFF0);
		log_entry(LOG_XOR, 32'hF0F0FF00, 32'hFF00F0F0, 32'h0FF00FF0);
		log_entry(LOG_NAND, 32'hF0F0FF00, 32'hFF00F0F0, 32'h0FFF0FFF);
		log_entry(LOG_NOR, 32'hF0F0FF00, 32'hFF00F0F0, 32'h000F000F);
		log_entry(LOG_XNOR, 32'hF0F0FF00, 32'hFF00F0F0, 32'hF00FF00F);
		log_entry(LOG_SETBIT, 32'h00000000, 32'h0000001F, 32'h80000000);
		log_entry(LOG_CLRBIT, 32'hFFFFFFFF, 32'h00000000, 32'hFFFFFFFE);
		log_entry(LOG_BITREV, 32'hF0000001, 32'h00000000, 32'h8000000F);	// Bits 28 to 31
		log_entry(LOG_BYTEREV, 32'h12345678, 32'h00000000, 32'h78563412);
		log_entry(LOG_GETBIT, 32'h00008000, 32'h0000000F, 32'h00000001);
		log_entry(LOG_BYTEEXT, 32'hA1B2C3D4, 32'h00000000, 32'h000000D4);
		log_entry(LOG_BYTEEXT, 32'hA1B2C3D4, 32'h00000001, 32'h000000C3);
		log_entry(LOG_BYTEEXT, 32'hA1B2C3D4, 32'h00000002, 32'h000000B2);
		log_entry(LOG_BYTEEXT, 32'hA1B2C3D4, 32'h00000003, 32'h000000A1);
		log_entry(LOG_SETLOW, 32'h12345678, 32'h0000ABCD, 32'h1234ABCD);
		log_entry(LOG_SETHIGH, 32'h12345678, 32'h0000ABCD, 32'hABCD5678);
		log_entry(LOG_SIMM, 32'h00000000, 32'h00008001, 32'hFFFF8001);
		log_entry(LOG_UIMM, 32'h00000000, 32'hFFFF8001, 32'h00008001);
		log_entry(LOG_CLRWORD, 32'h12345678, 32'h00000000, 32'h00000000);
		log_entry(LOG_SETWORD, 32'h12345678, 32'h00000000, 32'hFFFFFFFF);
		log_entry(5'h13, 32'hCAFE0001, 32'h12345678, 32'hCAFE0001);	// Unlisted code
		shift_entry(SH_SLL, 32'h80000003, 32'h00000000, 32'h80000003, 1'b0);
		shift_entry(SH_SLL, 32'h80000003, 32'h00000001, 32'h00000006, 1'b1);
		shift_entry(SH_SLL, 32'h80000003, 32'h0000001F, 32'h80000000, 1'b1);
		shift_entry(SH_SRL, 32'h80000003, 32'h00000000, 32'h80000003, 1'b0);
		shift_entry(SH_SRL, 32'h80000003, 32'h00000001, 32'h40000001, 1'b1);
		shift_entry(SH_SRL, 32'h80000003, 32'h0000001F, 32'h00000001, 1'b0);
		shift_entry(SH_SRA, 32'h80000003, 32'h00000000, 32'h80000003, 1'b0);
		shift_entry(SH_SRA, 32'h80000003, 32'h00000001, 32'hC0000001, 1'b1);
		shift_entry(SH_SRA, 32'h80000003, 32'h0000001F, 32'hFFFFFFFF, 1'b0);
		shift_entry(SH_ROL, 32'h80000003, 32'h00000000, 32'h80000003, 1'b0);
		shift_entry(SH_ROL, 32'h80000003, 32'h00000001, 32'h00000007, 1'b1);
		shift_entry(SH_ROL, 32'h80000003, 32'h0000001F, 32'hC0000001, 1'b1);
		shift_entry(SH_ROR, 32'h80000003, 32'h00000000, 32'h80000003, 1'b0);
		shift_entry(SH_ROR, 32'h80000003, 32'h00000001, 32'hC0000001, 1'b1);
		shift_entry(SH_ROR, 32'h80000003, 32'h0000001F, 32'h00000007, 1'b0);
		adder_entry(ADD_ADD, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 1'b1, 1'b0);
		adder_entry(ADD_ADD, 32'h7FFFFFFF, 32'h00000001, 32'h80000000, 1'b0, 1'b1);
		adder_entry(ADD_ADD, 32'h80000000, 32'h80000000, 32'h00000000, 1'b1, 1'b1);
		adder_entry(ADD_SUB, 32'h00000001, 32'h00000002, 32'hFFFFFFFF, 1'b1, 1'b0);
		adder_entry(ADD_SUB, 32'h80000000, 32'h00000001, 32'h7FFFFFFF, 1'b0, 1'b1);
		adder_entry(ADD_SUB, 32'h7FFFFFFF, 32'hFFFFFFFF, 32'h80000000, 1'b1, 1'b1);
		adder_entry(ADD_SUB, 32'h12345678, 32'h12345678, 32'h00000000, 1'b0, 1'b0);
	endtask

	// Adder reference, written from the add and subtract rules
	task automatic model_adder(input cmd_t op, input word_t a, input word_t b,
		output word_t res, output flags_t fl);
		logic [32:0] wide;
		logic        cf;
		logic        of;
		if (op == ADD_SUB)
		begin
			res = a - b;
			cf  = (a < b);	// Borrow
			of  = (a[31] != b[31]) && (res[31] != a[31]);
		end
		else
		begin
			wide = {1'b0, a} + {1'b0, b};
			res  = wide[31:0];
			cf   = wide[32];
			of   = (a[31] == b[31]) && (res[31] != a[31]);
		end
		fl = flags_for(res, cf, of);
	endtask

	task automatic drive_cmd(unit_t u, cmd_t c, word_t a, word_t b);
		in_valid = 1'b1;
		unit     = u;
		cmd      = c;
		data0    = a;
		data1    = b;
	endtask

	task automatic wait_out_valid();
		int n;
		n = 0;
		while (out_valid !== 1'b1)
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("out_valid never came after the command strobe");
				stop_run();
			end
			@(negedge clock);
			n++;
		end
	endtask

	task automatic run_cmd(unit_t u, cmd_t c, word_t a, word_t b, word_t exp_res,
		flags_t exp_fl);
		@(negedge clock);
		drive_cmd(u, c, a, b);
		@(negedge clock);
		in_valid = 1'b0;
		wait_out_valid();
		check_word("result", exp_res, result);
		check_flags("flags", exp_fl, flags);
	endtask

	task automatic check_reset();
		int n;
		n = 0;
		@(negedge clock);
		while (rst_n !== 1'b1)
		begin
			if (n == WAIT_LIMIT)
			begin
				$display("rst_n was never released");
				stop_run();
			end
			check_bit("out_valid", 1'b0, out_valid);
			@(negedge clock);
			n++;
		end
		repeat (3)
		begin
			@(negedge clock);
			check_bit("out_valid", 1'b0, out_valid);	// Idle after reset
			check_word("result", 32'h0, result);
			check_flags("flags", 5'h0, flags);
		end
	endtask

	task automatic random_adder(int count);
		word_t  a;
		word_t  b;
		word_t  rnd;
		word_t  res;
		cmd_t   op;
		flags_t fl;
		for (int i = 0; i < count; i++)
		begin
			a   = $urandom;
			b   = $urandom;
			rnd = $urandom;
			op  = rnd[0] ? ADD_SUB : ADD_ADD;
			model_adder(op, a, b, res, fl);
			run_cmd(UNIT_ADD, op, a, b, res, fl);
		end
	endtask

	// Eight strobes in a row, each result checked one cycle later
	task automatic back_to_back();
		word_t  exp_res[8];
		flags_t exp_fl[8];
		word_t  a;
		int     idx;
		for (int k = 0; k <= 8; k++)
		begin
			@(negedge clock);
			if (k > 0)
			begin
				check_bit("out_valid", 1'b1, out_valid);
				check_word("result", exp_res[k - 1], result);
				check_flags("flags", exp_fl[k - 1], flags);
			end
			if (k < 8)
			begin
				idx = (k * 7) % tbl_unit.size();	// Mix of all three units
				drive_cmd(tbl_unit[idx], tbl_cmd[idx], tbl_data0[idx], tbl_data1[idx]);
				exp_res[k] = tbl_result[idx];
				exp_fl[k]  = tbl_flags[idx];
			end
			else
			begin
				in_valid = 1'b0;
				unit     = UNIT_LOGIC;
				cmd      = LOG_INV0;
				data0    = exp_res[7];	// Idle inputs now select the inverse
			end
		end
		@(negedge clock);
		check_bit("out_valid", 1'b0, out_valid);	// Gap cycle holds outputs
		check_word("result", exp_res[7], result);
		check_flags("flags", exp_fl[7], flags);
		a = $urandom;
		run_cmd(2'd3, ADD_SUB, a, 32'h12345678, a, flags_for(a, 1'b0, 1'b0));	// Every unit alters data0
	endtask

	initial
	begin
		in_valid = 1'b0;
		unit     = UNIT_LOGIC;
		cmd      = '0;
		data0    = '0;
		data1    = '0;
		void'($urandom(41));
		build_table();
		check_reset();
		for (int i = 0; i < tbl_unit.size(); i++)
		begin
			run_cmd(tbl_unit[i], tbl_cmd[i], tbl_data0[i], tbl_data1[i], tbl_result[i],
				tbl_flags[i]);
		end
		random_adder(64);
		back_to_back();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic clock,
	output logic rst_n
);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (4) @(posedge clock);	// Four reset cycles
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top
	import exec_pkg::*;
(
	input  logic   clock,
	input  logic   rst_n,
	input  logic   in_valid,	// One command per strobe
	input  unit_t  unit,
	input  cmd_t   cmd,
	input  word_t  data0,
	input  word_t  data1,
	output logic   out_valid,
	output word_t  result,
	output flags_t flags
);

	word_t logic_result;
	word_t shift_result;
	word_t add_result;
	logic  shift_cf;
	logic  add_cf;
	logic  add_of;

	// All three units see every command, the stage picks one
	logic_unit i_logic_unit
	(
		.cmd    (cmd),
		.data0  (data0),
		.data1  (data1),
		.result (logic_result)
	);

	shift_unit i_shift_unit
	(
		.cmd    (cmd),
		.data0  (data0),
		.data1  (data1),
		.result (shift_result),
		.cf     (shift_cf)
	);

	adder_unit i_adder_unit
	(
		.cmd    (cmd),
		.data0  (data0),
		.data1  (data1),
		.result (add_result),
		.cf     (add_cf),
		.of     (add_of)
	);

	// Result select, flags and output register
	exec_stage i_exec_stage
	(
		.clock        (clock),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.unit         (unit),
		.data0        (data0),
		.logic_result (logic_result),
		.shift_result (shift_result),
		.add_result   (add_result),
		.shift_cf     (shift_cf),
		.add_cf       (add_cf),
		.add_of       (add_of),
		.out_valid    (out_valid),
		.result       (result),
		.flags        (flags)
	);

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage
	import exec_pkg::*;
(
	input  logic   clock,
	input  logic   rst_n,
	input  logic   in_valid,
	input  unit_t  unit,
	input  word_t  data0,
	input  word_t  logic_result,
	input  word_t  shift_result,
	input  word_t  add_result,
	input  logic   shift_cf,
	input  logic   add_cf,
	input  logic   add_of,
	output logic   out_valid,
	output word_t  result,
	output flags_t flags
);

	word_t  sel_result;
	logic   sel_cf;
	logic   sel_of;
	flags_t next_flags;

	always_comb
	begin
		case (unit)
			UNIT_LOGIC:
			begin
				sel_result = logic_result;
				sel_cf     = 1'b0;
				sel_of     = 1'b0;
			end
			UNIT_SHIFT:
			begin
				sel_result = shift_result;
				sel_cf     = shift_cf;
				sel_of     = 1'b0;	// Shifts never overflow
			end
			UNIT_ADD:
			begin
				sel_result = add_result;
				sel_cf     = add_cf;
				sel_of     = add_of;
			end
			default:
			begin
				sel_result = data0;	// Reserved unit echoes data0
				sel_cf     = 1'b0;
				sel_of     = 1'b0;
			end
		endcase
	end

	assign next_flags.sf = sel_result[31];
	assign next_flags.of = sel_of;
	assign next_flags.cf = sel_cf;
	assign next_flags.pf = sel_result[0];
	assign next_flags.zf = (sel_result == '0);

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
			flags     <= '0;
		end
		else
		begin
			out_valid <= in_valid;	// One cycle pulse per command
			if (in_valid)
			begin
				result <= sel_result;
				flags  <= next_flags;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/adder_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module adder_unit
	import exec_pkg::*;
(
	input  cmd_t  cmd,
	input  word_t data0,
	input  word_t data1,
	output word_t result,
	output logic  cf,
	output logic  of
);

	logic        is_sub;
	word_t       operand_b;	// data1 or its complement
	logic [32:0] sum;
	logic        sum_of;

	// Subtract runs as data0 + ~data1 + 1
	assign is_sub    = (cmd == ADD_SUB);
	assign operand_b = is_sub ? ~data1 : data1;
	assign sum       = {1'b0, data0} + {1'b0, operand_b} + {32'h0, is_sub};

	// Same input signs, different result sign
	assign sum_of = (data0[31] == operand_b[31]) && (sum[31] != data0[31]);

	always_comb
	begin
		case (cmd)
			ADD_ADD:
			begin
				result = sum[31:0];
				cf     = sum[32];
				of     = sum_of;
			end
			ADD_SUB:
			begin
				result = sum[31:0];
				cf     = ~sum[32];	// Borrow, data0 below data1 unsigned
				of     = sum_of;
			end
			default:
			begin
				result = data0;
				cf     = 1'b0;
				of     = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/shift_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_unit
	import exec_pkg::*;
(
	input  cmd_t  cmd,
	input  word_t data0,
	input  word_t data1,
	output word_t result,
	output logic  cf
);

	logic [4:0]  amount;
	logic [32:0] sll_ext;	// Carry bit above the word
	logic [32:0] srl_ext;	// Carry bit below the word
	logic [32:0] sra_ext;
	logic [63:0] rol_dbl;	// Doubled word for rotates
	logic [63:0] ror_dbl;

	assign amount  = data1[4:0];
	assign sll_ext = {1'b0, data0} << amount;
	assign srl_ext = {data0, 1'b0} >> amount;
	assign sra_ext = $signed({data0, 1'b0}) >>> amount;
	assign rol_dbl = {data0, data0} << amount;
	assign ror_dbl = {data0, data0} >> amount;

	always_comb
	begin
		result = data0;
		cf     = 1'b0;
		case (cmd)
			SH_SLL:
			begin
				result = sll_ext[31:0];
				cf     = sll_ext[32];	// Last bit out of bit 31
			end
			SH_SRL:
			begin
				result = srl_ext[32:1];
				cf     = srl_ext[0];
			end
			SH_SRA:
			begin
				result = sra_ext[32:1];
				cf     = sra_ext[0];
			end
			SH_ROL:
			begin
				result = rol_dbl[63:32];
				cf     = (amount != 5'd0) ? rol_dbl[32] : 1'b0;	// Wrapped into bit 0
			end
			SH_ROR:
			begin
				result = ror_dbl[31:0];
				cf     = (amount != 5'd0) ? ror_dbl[31] : 1'b0;	// Wrapped into bit 31
			end
			default:
			begin
				result = data0;
				cf     = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/logic_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module logic_unit
	import exec_pkg::*;
(
	input  cmd_t  cmd,
	input  word_t data0,
	input  word_t data1,
	output word_t result
);

	word_t bit_rev;	// data0 mirrored, bit 0 to bit 31
	word_t bit_mask;	// One-hot mask from data1[4:0]
	word_t byte_sel;	// Byte lane picked by data1[1:0]

	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			bit_rev[i] = data0[31 - i];
		end
	end

	assign bit_mask = word_t'(1) << data1[4:0];

	always_comb
	begin
		case (data1[1:0])
			2'd0:
			begin
				byte_sel = {24'h0, data0[7:0]};
			end
			2'd1:
			begin
				byte_sel = {24'h0, data0[15:8]};
			end
			2'd2:
			begin
				byte_sel = {24'h0, data0[23:16]};
			end
			default:
			begin
				byte_sel = {24'h0, data0[31:24]};
			end
		endcase
	end

	always_comb
	begin
		case (cmd)
			LOG_BUF0:
				result = data0;
			LOG_BUF1:
				result = data1;
			LOG_INV0:
				result = ~data0;
			LOG_INV1:
				result = ~data1;
			LOG_AND:
				result = data0 & data1;
			LOG_OR:
				result = data0 | data1;
			LOG_XOR:
				result = data0 ^ data1;
			LOG_NAND:
				result = ~(data0 & data1);
			LOG_NOR:
				result = ~(data0 | data1);
			LOG_XNOR:
				result = ~(data0 ^ data1);
			LOG_SETBIT:
				result = data0 | bit_mask;
			LOG_CLRBIT:
				result = data0 & ~bit_mask;
			LOG_BITREV:
				result = bit_rev;
			LOG_BYTEREV:
				result = {data0[7:0], data0[15:8], data0[23:16], data0[31:24]};
			LOG_GETBIT:
				result = {31'h0, data0[data1[4:0]]};	// Selected bit lands in bit 0
			LOG_BYTEEXT:
				result = byte_sel;
			LOG_SETLOW:
				result = {data0[31:16], data1[15:0]};	// Replace low half
			LOG_SETHIGH:
				result = {data1[15:0], data0[15:0]};	// Replace high half
			LOG_SIMM:
				result = {{16{data1[15]}}, data1[15:0]};	// Sign extend
			LOG_UIMM:
				result = {16'h0, data1[15:0]};	// Zero extend
			LOG_CLRWORD:
				result = '0;
			LOG_SETWORD:
				result = '1;
			default:
			begin
				// Code 0x13 and anything above 0x16 fall through unchanged
				result = data0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	typedef logic [31:0] word_t;	// Data word
	typedef logic [4:0]  cmd_t;	// Operation code, meaning depends on unit
	typedef logic [1:0]  unit_t;	// Unit select, value 3 reserved

	typedef struct packed
	{
		logic sf;	// Sign
		logic of;	// Signed overflow
		logic cf;	// Carry or borrow
		logic pf;	// Bit 0 of result
		logic zf;	// Zero result
	} flags_t;

	localparam unit_t UNIT_LOGIC   = 2'd0;
	localparam unit_t UNIT_SHIFT   = 2'd1;
	localparam unit_t UNIT_ADD     = 2'd2;

	localparam cmd_t LOG_BUF0      = 5'h00;
	localparam cmd_t LOG_BUF1      = 5'h01;
	localparam cmd_t LOG_INV0      = 5'h02;
	localparam cmd_t LOG_INV1      = 5'h03;
	localparam cmd_t LOG_AND       = 5'h04;
	localparam cmd_t LOG_OR        = 5'h05;
	localparam cmd_t LOG_XOR       = 5'h06;
	localparam cmd_t LOG_NAND      = 5'h07;
	localparam cmd_t LOG_NOR       = 5'h08;
	localparam cmd_t LOG_XNOR      = 5'h09;
	localparam cmd_t LOG_SETBIT    = 5'h0A;
	localparam cmd_t LOG_CLRBIT    = 5'h0B;
	localparam cmd_t LOG_BITREV    = 5'h0C;
	localparam cmd_t LOG_BYTEREV   = 5'h0D;
	localparam cmd_t LOG_GETBIT    = 5'h0E;
	localparam cmd_t LOG_BYTEEXT   = 5'h0F;
	localparam cmd_t LOG_SETLOW    = 5'h10;
	localparam cmd_t LOG_SETHIGH   = 5'h11;
	localparam cmd_t LOG_SIMM      = 5'h12;	// Signed immediate load
	localparam cmd_t LOG_UIMM      = 5'h14;	// Unsigned immediate load
	localparam cmd_t LOG_CLRWORD   = 5'h15;
	localparam cmd_t LOG_SETWORD   = 5'h16;

	localparam cmd_t SH_SLL        = 5'd0;
	localparam cmd_t SH_SRL        = 5'd1;
	localparam cmd_t SH_SRA        = 5'd2;
	localparam cmd_t SH_ROL        = 5'd3;
	localparam cmd_t SH_ROR        = 5'd4;

	localparam cmd_t ADD_ADD       = 5'd0;
	localparam cmd_t ADD_SUB       = 5'd1;

endpackage

`default_nettype wire
